// File: bench/tb_stim.sv
/* testbench for stim_top: loads a record table, plays it twice under a
   random credit-return model and checks order, pauses, credits and done */

`include "stim_defines.svh"

module tb_stim;
   import stim_pkg::*;

   localparam int nrec = 12; // records before the end marker

   // ##############################
   // record table, payload is also the expected packet
   // ##############################

   localparam logic [`STIM_UW-1:0] tbl_payload [0:nrec-1] = '{
      32'h1000_0001, 32'h2222_0002, 32'h3c3c_0003, 32'h4000_0004,
      32'h5a5a_0005, 32'h6006_0006, 32'h7777_0007, 32'h8001_0008,
      32'h9999_0009, 32'ha0a0_000a, 32'hbeef_000b, 32'hc0de_000c
   };
   localparam logic [`STIM_CW-2:0] tbl_delay [0:nrec-1] = '{
      7'd0, 7'd3, 7'd0, 7'd5, 7'd1, 7'd0,
      7'd2, 7'd4, 7'd0, 7'd0, 7'd5, 7'd1
   };

   logic                dut_clk;
   logic                nreset;
   logic                load;
   logic                load_valid;
   stim_rec_t           load_record;
   logic                load_ready;
   logic                go;
   logic                credit_return = 1'b0; // owned by the credit model
   logic                stim_valid;
   logic [`STIM_UW-1:0] stim_packet;
   logic                stim_done;

   // monitor state
   int          cyc = 0;         // cycles since reset release
   int          accepted = 0;    // load handshakes seen
   int          pkt_count = 0;   // packets seen over the whole run
   int          outstanding = 0; // sends minus returns
   int          last_cyc = 0;
   logic [`STIM_CW-2:0] last_delay = '0;
   int          due_q [$];       // cycle each credit goes back
   logic [16:0] lfsr = 17'd72045;

   stim_top stim_top_i
   (
      .dut_clk       (dut_clk),
      .nreset        (nreset),
      .load          (load),
      .load_valid    (load_valid),
      .load_record   (load_record),
      .load_ready    (load_ready),
      .go            (go),
      .credit_return (credit_return),
      .stim_valid    (stim_valid),
      .stim_packet   (stim_packet),
      .stim_done     (stim_done)
   );

   initial
   begin
      dut_clk = 1'b0;
      forever #4 dut_clk = ~dut_clk; // period 8
   end

   // ##############################
   // helpers
   // ##############################

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("Errors found");
      $fatal(1, "run stopped at first error");
   endtask

   // x^17 + x^14 + 1
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   function automatic stim_rec_t make_rec(input int idx);
      stim_rec_t r;
      if (idx < nrec)
      begin
         r.payload = tbl_payload[idx];
         r.ctrl    = {tbl_delay[idx], 1'b1};
      end
      else
      begin
         r.payload = 32'hdead_beef; // must never show up
         r.ctrl    = '0;            // end marker
      end
      return r;
   endfunction

   // ##############################
   // packet monitor and credit-return model
   // ##############################

   always @(posedge dut_clk)
   begin : monitor
      logic [2:0] d;
      int         b;
      int         idx;
      if (nreset)
      begin
         cyc = cyc + 1;
         if (load_valid && load_ready)
         begin
            accepted = accepted + 1; // record taken at this edge
         end
         if (stim_valid)
         begin
            idx = pkt_count % nrec;
            assert (outstanding < `STIM_CREDITS) else
               stop_run($sformatf("Fail %0t: stim_valid with no credit left", $time));
            assert (stim_packet == tbl_payload[idx]) else
               stop_run($sformatf("Fail %0t: packet %0d is %h, expected %h",
                  $time, idx, stim_packet, tbl_payload[idx]));
            if (idx != 0)
            begin
               assert (cyc - last_cyc >= int'(last_delay) + 1) else
                  stop_run($sformatf("Fail %0t: gap %0d before packet %0d, delay was %0d",
                     $time, cyc - last_cyc, idx, last_delay));
            end
            last_cyc   = cyc;
            last_delay = tbl_delay[idx];
            pkt_count  = pkt_count + 1;
            outstanding = outstanding + 1;
            d = '0;
            for (b = 0; b < 3; b++)
            begin
               lfsr = lfsr_next(lfsr); // one step per bit
               d    = {d[1:0], lfsr[0]};
            end
            due_q.push_back(cyc + int'(d));
         end
         if (credit_return)
         begin
            outstanding = outstanding - 1;
         end
         // at most one return pulse per cycle
         if (due_q.size() > 0 && due_q[0] <= cyc)
         begin
            credit_return <= 1'b1;
            void'(due_q.pop_front());
         end
         else
         begin
            credit_return <= 1'b0;
         end
      end
   end

   // ##############################
   // one play pass
   // ##############################

   task automatic play_pass(input int pass_no);
      int n;
      go <= 1'b1;
      n = 0;
      while (!stim_done && n < 4000)
      begin
         @(posedge dut_clk);
         n++;
      end
      if (!stim_done)
      begin
         stop_run($sformatf("timed out waiting for stim_done in pass %0d", pass_no));
      end
      assert (pkt_count == nrec * pass_no) else
         stop_run($sformatf("Fail %0t: %0d packets before done, pass %0d",
            $time, pkt_count, pass_no));
      for (n = 0; n < 6; n++) // done holds while go stays high
      begin
         @(posedge dut_clk);
         assert (stim_done) else
            stop_run($sformatf("Fail %0t: stim_done fell with go high", $time));
      end
      go <= 1'b0;
      n = 0;
      do
      begin
         @(posedge dut_clk);
         n++;
      end
      while (stim_done && n < 20);
      if (stim_done)
      begin
         stop_run("timed out waiting for stim_done to fall after go dropped");
      end
      assert (pkt_count == nrec * pass_no) else
         stop_run($sformatf("Fail %0t: packets sent after the end marker", $time));
      n = 0;
      while (outstanding != 0 && n < 100) // let every credit come home
      begin
         @(posedge dut_clk);
         n++;
      end
      if (outstanding != 0)
      begin
         stop_run("timed out waiting for the credits to return");
      end
   endtask

   // ##############################
   // main sequence
   // ##############################

   initial
   begin : main
      int n;
      int i;
      nreset      = 1'b0;
      load        = 1'b0;
      load_valid  = 1'b0;
      load_record = '0;
      go          = 1'b0;
      repeat (10) @(posedge dut_clk);
      assert (!stim_valid && !stim_done && !load_ready) else
         stop_run($sformatf("Fail %0t: outputs not low in reset", $time));
      nreset <= 1'b1;
      @(posedge dut_clk);

      // load table plus end marker
      load   <= 1'b1;
      for (i = 0; i <= nrec; i++)
      begin
         load_valid  <= 1'b1;
         load_record <= make_rec(i);
         n = 0;
         do
         begin
            @(posedge dut_clk);
            n++;
         end
         while (!load_ready && n < 50);
         if (!load_ready)
         begin
            stop_run($sformatf("timed out waiting for load_ready on record %0d", i));
         end
      end
      load_valid <= 1'b0;
      load       <= 1'b0;
      @(posedge dut_clk);
      assert (accepted == nrec + 1) else
         stop_run($sformatf("Fail %0t: %0d records loaded", $time, accepted));

      play_pass(1);
      @(posedge dut_clk);
      play_pass(2); // replay from address 0

      assert (pkt_count == 2 * nrec) else
         stop_run($sformatf("Fail %0t: %0d packets in total", $time, pkt_count));
      $display("No errors");
      $finish;
   end

endmodule

// File: common/stim_defines.svh
/* widths, depth and credit count shared by the stimulus player.
   include wherever a record field, address or credit limit is sized */

`ifndef STIM_DEFINES_SVH
`define STIM_DEFINES_SVH

// ############################
// record layout
// ############################

`define STIM_UW 32 // payload bits sent to the dut
`define STIM_CW 8  // ctrl bits, bit 0 valid, rest idle count

// ############################
// memory
// ############################

`define STIM_DEPTH 256 // records held on chip
`define STIM_AW 8      // log2 of depth

// ############################
// flow control
// ############################

`define STIM_CREDITS 4 // credits at reset, also the ceiling

`endif

// File: common/stim_mem_if.sv
/* request/response link between one memory peer and the arbiter.
   one instance per peer; peers use requester, the arbiter uses arbiter */

`include "stim_defines.svh"

interface stim_mem_if;
   import stim_pkg::*;

   logic                req;    // held until gnt
   logic                gnt;    // comb from req
   mem_op_t             op;     // read or write
   logic [`STIM_AW-1:0] addr;   // record index
   stim_rec_t           wdata;  // write payload
   stim_rec_t           rdata;  // valid with rvalid
   logic                rvalid; // one cycle after a read grant

   modport requester
   (
      output req, op, addr, wdata,
      input  gnt, rdata, rvalid
   );

   modport arbiter
   (
      input  req, op, addr, wdata,
      output gnt, rdata, rvalid
   );

endinterface

// File: common/stim_pkg.sv
/* record, state and opcode types for the stimulus player.
   modules import what they use inside their bodies */

`include "stim_defines.svh"

package stim_pkg;

   // one table entry as stored in memory
   // payload sits above ctrl, same packing as the host word
   typedef struct packed
   {
      logic [`STIM_UW-1:0] payload; // goes out on stim_packet
      logic [`STIM_CW-1:0] ctrl;    // [0] valid, [cw-1:1] delay
   } stim_rec_t;

   // player read fsm
   typedef enum logic [2:0]
   {
      ST_IDLE,  // waiting for go
      ST_FETCH, // read request out
      ST_WAIT,  // read data due next cycle
      ST_SEND,  // holding record until a credit shows up
      ST_PAUSE, // idle cycles from the delay field
      ST_DONE   // end marker seen
   } player_state_t;

   // memory request opcode
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_t;

endpackage

// File: hw/mem_arbiter.sv
/* round-robin arbiter of loader and player onto one stim_ram.
   grant is comb from req; read data returns to the issuing port a cycle later */

`include "stim_defines.svh"

module mem_arbiter
(
   input  logic       dut_clk,
   input  logic       nreset,
   stim_mem_if.arbiter load_port, // loader side
   stim_mem_if.arbiter play_port  // player side
);
   import stim_pkg::*;

   logic                load_gnt;
   logic                play_gnt;
   logic                last_play; // last grant went to player
   logic                rd_pend;   // read issued last cycle
   logic                rd_play;   // ...and it was the player's
   logic                ram_en;
   logic                ram_we;
   logic [`STIM_AW-1:0] ram_addr;
   stim_rec_t           ram_wdata;
   stim_rec_t           ram_rdata;

   // ############################
   // grant
   // ############################

   // on conflict the peer not served last wins
   assign load_gnt = load_port.req && (!play_port.req || last_play);
   assign play_gnt = play_port.req && (!load_port.req || !last_play);

   assign load_port.gnt = load_gnt;
   assign play_port.gnt = play_gnt;

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         last_play <= 1'b0; // player first on a tie
         rd_pend   <= 1'b0;
         rd_play   <= 1'b0;
      end
      else
      begin
         if (load_gnt || play_gnt)
         begin
            last_play <= play_gnt;
         end
         rd_pend <= ram_en && !ram_we; // matches ram read latency
         rd_play <= play_gnt;
      end
   end

   // ############################
   // ram port mux
   // ############################

   assign ram_en    = load_gnt || play_gnt;
   assign ram_we    = load_gnt ? (load_port.op == OP_WRITE) : (play_port.op == OP_WRITE);
   assign ram_addr  = load_gnt ? load_port.addr  : play_port.addr;
   assign ram_wdata = load_gnt ? load_port.wdata : play_port.wdata;

   stim_ram stim_ram_i
   (
      .dut_clk (dut_clk),
      .en      (ram_en),
      .we      (ram_we),
      .addr    (ram_addr),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   // response steering
   assign load_port.rdata  = ram_rdata;
   assign play_port.rdata  = ram_rdata;
   assign load_port.rvalid = rd_pend && !rd_play;
   assign play_port.rvalid = rd_pend && rd_play;

   // one owner per ram cycle
   a_one_gnt : assert property (@(posedge dut_clk) disable iff (!nreset)
      !(load_gnt && play_gnt));

   // a peer that lost a conflict is served next cycle if it still asks
   a_load_wait : assert property (@(posedge dut_clk) disable iff (!nreset)
      load_port.req && !load_gnt |=> !load_port.req || load_gnt);

   a_play_wait : assert property (@(posedge dut_clk) disable iff (!nreset)
      play_port.req && !play_gnt |=> !play_port.req || play_gnt);

endmodule

// File: hw/stim_loader.sv
/* writes host records to consecutive addresses while load is high.
   load_ready is the arbiter grant; dropping load restarts at address 0 */

`include "stim_defines.svh"

module stim_loader
(
   input  logic                 dut_clk,
   input  logic                 nreset,
   input  logic                 load,        // host owns the table
   input  logic                 load_valid,  // record offered
   input  stim_pkg::stim_rec_t  load_record,
   output logic                 load_ready,  // record taken this cycle
   stim_mem_if.requester        mem
);
   import stim_pkg::*;

   localparam logic [`STIM_AW-1:0] last_addr = `STIM_AW'(`STIM_DEPTH - 1);

   logic [`STIM_AW-1:0] wr_addr; // next slot
   logic                wr_full; // last slot written

   // ############################
   // request
   // ############################

   // req and payload follow the host, host holds them until ready
   assign mem.req   = load && load_valid;
   assign mem.op    = OP_WRITE;
   assign mem.addr  = wr_addr;
   assign mem.wdata = load_record;

   assign load_ready = mem.gnt;

   // read side unused by the loader

   // ############################
   // address counter
   // ############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_addr <= '0;
         wr_full <= 1'b0;
      end
      else if (!load)
      begin
         wr_addr <= '0; // next load starts over
         wr_full <= 1'b0;
      end
      else if (mem.gnt)
      begin
         wr_addr <= wr_addr + 1'b1;
         if (wr_addr == last_addr)
         begin
            wr_full <= 1'b1;
         end
      end
   end

   // host must not push past the last slot
   a_no_wrap : assert property (@(posedge dut_clk) disable iff (!nreset)
      mem.req |-> !wr_full);

endmodule

// File: hw/stim_ram.sv
/* single-port record store behind the arbiter.
   writes on en and we; reads register data one cycle after en */

`include "stim_defines.svh"

module stim_ram
(
   input  logic                dut_clk,
   input  logic                en,    // access this cycle
   input  logic                we,    // 1 write, 0 read
   input  logic [`STIM_AW-1:0] addr,
   input  stim_pkg::stim_rec_t wdata,
   output stim_pkg::stim_rec_t rdata  // one cycle latency
);
   import stim_pkg::*;

   stim_rec_t mem [0:`STIM_DEPTH-1]; // record table, filled by the loader

   // ############################
   // single port
   // ############################

   always_ff @(posedge dut_clk)
   begin
      if (en && we)
      begin
         mem[addr] <= wdata;
      end
   end

   // read data held until the next read
   always_ff @(posedge dut_clk)
   begin
      if (en && !we)
      begin
         rdata <= mem[addr];
      end
   end

endmodule

// File: hw/stim_top.sv
/* stimulus player top level with plain host and dut ports.
   loader and player share one ram through the round-robin arbiter */

`include "stim_defines.svh"

module stim_top
(
   input  logic                dut_clk,
   input  logic                nreset,
   // host load side
   input  logic                load,
   input  logic                load_valid,
   input  stim_pkg::stim_rec_t load_record,
   output logic                load_ready,
   // dut side
   input  logic                go,
   input  logic                credit_return,
   output logic                stim_valid,
   output logic [`STIM_UW-1:0] stim_packet,
   output logic                stim_done
);

   // one link per memory peer
   stim_mem_if load_if ();
   stim_mem_if play_if ();

   // ############################
   // write path
   // ############################

   stim_loader stim_loader_i
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .load        (load),
      .load_valid  (load_valid),
      .load_record (load_record),
      .load_ready  (load_ready),
      .mem         (load_if.requester)
   );

   // ############################
   // read path
   // ############################

   stim_player stim_player_i
   (
      .dut_clk       (dut_clk),
      .nreset        (nreset),
      .go            (go),
      .credit_return (credit_return),
      .stim_valid    (stim_valid),
      .stim_packet   (stim_packet),
      .stim_done     (stim_done),
      .mem           (play_if.requester)
   );

   // arbiter owns the ram
   mem_arbiter mem_arbiter_i
   (
      .dut_clk   (dut_clk),
      .nreset    (nreset),
      .load_port (load_if.arbiter),
      .play_port (play_if.arbiter)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the stimulus player testbench with verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
   -f sim.f --top-module tb_stim -o tb_stim

# the run may stop on a failed check, the log decides
./obj_dir/tb_stim > sim.log 2>&1 || true
cat sim.log

if grep -q "No errors" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: sim.f
+incdir+common
common/stim_pkg.sv
common/stim_mem_if.sv
hw/stim_ram.sv
hw/mem_arbiter.sv
hw/stim_loader.sv
stim_player/stim_player.sv
hw/stim_top.sv
bench/tb_stim.sv

// File: stim_player/stim_player.sv
/* reads records back in order and sends payloads to the dut under credit control.
   go starts play from address 0; stim_done holds until go drops */

`include "stim_defines.svh"

module stim_player
(
   input  logic                dut_clk,
   input  logic                nreset,
   input  logic                go,            // start, hold high for play
   input  logic                credit_return, // one credit back per pulse
   output logic                stim_valid,    // packet strobe
   output logic [`STIM_UW-1:0] stim_packet,
   output logic                stim_done,     // end marker reached
   stim_mem_if.requester       mem
);
   import stim_pkg::*;

   localparam int credit_w = $clog2(`STIM_CREDITS + 1);
   localparam logic [credit_w-1:0] credit_max = credit_w'(`STIM_CREDITS);

   player_state_t       state;
   logic [`STIM_AW-1:0] rd_addr;   // record being played
   stim_rec_t           rec;       // held until sent
   logic [`STIM_CW-2:0] pause_cnt; // idle cycles left
   logic [credit_w-1:0] credits;
   logic [`STIM_CW-2:0] delay;     // from the held record

   assign delay = rec.ctrl[`STIM_CW-1:1];

   // ############################
   // memory side
   // ############################

   assign mem.req   = (state == ST_FETCH);
   assign mem.op    = OP_READ;
   assign mem.addr  = rd_addr;
   assign mem.wdata = '0; // reads only

   // ############################
   // outputs
   // ############################

   assign stim_valid  = (state == ST_SEND) && (credits != '0);
   assign stim_packet = rec.payload;
   assign stim_done   = (state == ST_DONE);

   // ############################
   // read fsm
   // ############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= ST_IDLE;
         rd_addr   <= '0;
         pause_cnt <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (go) state <= ST_FETCH;
            ST_FETCH:
               if (mem.gnt) state <= ST_WAIT; // data back next cycle
            ST_WAIT:
               if (mem.rvalid)
               begin
                  state <= mem.rdata.ctrl[0] ? ST_SEND : ST_DONE; // flag 0 = end
               end
            ST_SEND:
               if (stim_valid)
               begin
                  rd_addr <= rd_addr + 1'b1;
                  if (delay == '0)
                  begin
                     state <= ST_FETCH; // no idle requested
                  end
                  else
                  begin
                     state     <= ST_PAUSE;
                     pause_cnt <= delay - 1'b1; // exactly delay idle cycles
                  end
               end
            ST_PAUSE:
               if (pause_cnt == '0) state <= ST_FETCH;
               else pause_cnt <= pause_cnt - 1'b1;
            ST_DONE:
               if (!go)
               begin
                  state   <= ST_IDLE;
                  rd_addr <= '0; // ready to replay
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // record capture on read return
   always_ff @(posedge dut_clk)
   begin
      if (state == ST_WAIT && mem.rvalid)
      begin
         rec <= mem.rdata;
      end
   end

   // ############################
   // credits
   // ############################

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         credits <= credit_max;
      end
      else if (credit_return && !stim_valid && credits != credit_max)
      begin
         credits <= credits + 1'b1;
      end
      else if (stim_valid && !credit_return)
      begin
         credits <= credits - 1'b1; // return + send together leaves it
      end
   end

   a_credit_max : assert property (@(posedge dut_clk) disable iff (!nreset)
      credits <= credit_max);

   // out of credits the record waits in send
   a_stall_hold : assert property (@(posedge dut_clk) disable iff (!nreset)
      (state == ST_SEND) && (credits == '0) |=> (state == ST_SEND) && $stable(rec));

endmodule
